// ==== src/rv32_core_pkg.sv ====
`default_nettype none

package rv32_core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int SHAMT_W    = 5;
  localparam int CSR_ADDR_W = 12;

  // Jump-to-self halt detection
  localparam bit              INFINITE_LOOP_HALTS = 1'b1;
  localparam logic [XLEN-1:0] HALT_INSN           = 32'h0000_006f;

  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  // funct3 of the immediate and register ALU groups
  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } alu_funct3_t;

  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    PRIV   = 3'b000,
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } system_t;

  typedef enum logic [11:0] {
    ECALL  = 12'h000,
    EBREAK = 12'h001,
    MRET   = 12'h302
  } priv_insn_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LINK = 2'd1,
    WB_UIMM = 2'd2
  } wsel_t;

  // Instruction formats, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  typedef struct packed {
    opcode_t                 opcode;
    logic [REG_ADDR_W-1:0]   rs1;
    logic [REG_ADDR_W-1:0]   rs2;
    logic [REG_ADDR_W-1:0]   rd;
    alu_op_t                 alu_op;
    logic                    alu_a_sel;  // 1 selects pc
    logic                    alu_b_sel;  // 1 selects imm
    logic [XLEN-1:0]         imm;
    wsel_t                   w_sel;
    logic                    wen;
    logic                    dren;
    logic                    dwen;
    load_t                   load_type;
    logic                    branch;
    branch_t                 branch_type;
    logic                    jump;
    logic                    csr_swap;
    logic                    csr_set;
    logic                    csr_clr;
    logic                    csr_imm;
    logic [CSR_ADDR_W-1:0]   csr_addr;
    logic [REG_ADDR_W-1:0]   zimm;
    logic                    ecall;
    logic                    ebreak;
    logic                    mret;
    logic                    illegal;
    logic                    halt;
  } ctrl_t;

  typedef struct packed {
    ctrl_t           ctrl;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] pc;
  } ex_req_t;

  typedef struct packed {
    logic            dren;
    logic            dwen;
    load_t           load_type;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  wen;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wdata;
    mem_req_t              mem_req;
    logic                  branch;
    branch_t               branch_type;
    logic                  jump;
    logic                  csr_swap;
    logic                  csr_set;
    logic                  csr_clr;
    logic                  csr_imm;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       csr_wdata;
    logic                  ecall;
    logic                  ebreak;
    logic                  mret;
    logic                  illegal;
    logic                  halt;
  } commit_t;

endpackage

`default_nettype wire

// ==== src/control_unit.sv ====
`default_nettype none

module control_unit import rv32_core_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output ctrl_t           ctrl_o
);

  rtype_t          r_fmt;
  itype_t          i_fmt;
  stype_t          s_fmt;
  sbtype_t         sb_fmt;
  utype_t          u_fmt;
  ujtype_t         uj_fmt;
  opcode_t         opcode;
  alu_funct3_t     alu_f3;
  system_t         sys_f3;
  priv_insn_t      priv;
  logic [XLEN-1:0] imm_i, imm_s, imm_sb, imm_u, imm_uj;
  logic [XLEN-1:0] imm_sel;
  alu_op_t         alu_op;
  logic            legal_op;
  logic            illegal;
  logic            wen_raw;
  logic            is_priv;
  logic            csr_swap, csr_set, csr_clr, csr_imm;

  // Overlay every format on the same word
  assign r_fmt  = rtype_t'(instr_i);
  assign i_fmt  = itype_t'(instr_i);
  assign s_fmt  = stype_t'(instr_i);
  assign sb_fmt = sbtype_t'(instr_i);
  assign u_fmt  = utype_t'(instr_i);
  assign uj_fmt = ujtype_t'(instr_i);

  assign opcode = r_fmt.opcode;
  assign alu_f3 = alu_funct3_t'(r_fmt.funct3);
  assign sys_f3 = system_t'(i_fmt.funct3);
  assign priv   = priv_insn_t'(i_fmt.imm11_00);

  // Sign-extended immediates
  assign imm_i  = {{(XLEN-12){i_fmt.imm11_00[11]}}, i_fmt.imm11_00};
  assign imm_s  = {{(XLEN-12){s_fmt.imm11_05[6]}}, s_fmt.imm11_05, s_fmt.imm04_00};
  assign imm_sb = {{(XLEN-13){sb_fmt.imm12}}, sb_fmt.imm12, sb_fmt.imm11,
                   sb_fmt.imm10_05, sb_fmt.imm04_01, 1'b0};
  assign imm_u  = {u_fmt.imm31_12, 12'b0};
  assign imm_uj = {{(XLEN-21){uj_fmt.imm20}}, uj_fmt.imm20, uj_fmt.imm19_12,
                   uj_fmt.imm11, uj_fmt.imm10_01, 1'b0};

  always_comb begin
    case (opcode)
      STORE:      imm_sel = imm_s;
      BRANCH:     imm_sel = imm_sb;
      LUI, AUIPC: imm_sel = imm_u;
      JAL:        imm_sel = imm_uj;
      default:    imm_sel = imm_i;
    endcase
  end

  // Bit 30 splits add/sub and srl/sra
  always_comb begin
    alu_op = ALU_ADD;
    if (opcode == IMMED || opcode == REGREG) begin
      case (alu_f3)
        ADDSUB:  alu_op = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
        SLL:     alu_op = ALU_SLL;
        SLT:     alu_op = ALU_SLT;
        SLTU:    alu_op = ALU_SLTU;
        XOR:     alu_op = ALU_XOR;
        SR:      alu_op = instr_i[30] ? ALU_SRA : ALU_SRL;
        OR:      alu_op = ALU_OR;
        AND:     alu_op = ALU_AND;
        default: alu_op = ALU_ADD;
      endcase
    end
  end

  always_comb begin
    case (opcode)
      LUI, AUIPC, JAL, JALR,
      BRANCH, LOAD, STORE,
      IMMED, REGREG,
      MISCMEM, SYSTEM: legal_op = 1'b1;
      default:         legal_op = 1'b0;
    endcase
  end

  // M-extension encodings are not supported
  assign illegal = !legal_op || (opcode == REGREG && r_fmt.funct7[0]);

  // Only ALU, upper-immediate and link results go back to the register file
  always_comb begin
    case (opcode)
      IMMED, REGREG, LUI,
      AUIPC, JAL, JALR: wen_raw = 1'b1;
      default:          wen_raw = 1'b0;
    endcase
  end

  assign is_priv = (opcode == SYSTEM) && (sys_f3 == PRIV);

  always_comb begin
    csr_swap = 1'b0;
    csr_set  = 1'b0;
    csr_clr  = 1'b0;
    csr_imm  = 1'b0;
    if (opcode == SYSTEM) begin
      case (sys_f3)
        CSRRW:   csr_swap = 1'b1;
        CSRRS:   csr_set  = 1'b1;
        CSRRC:   csr_clr  = 1'b1;
        CSRRWI:  {csr_swap, csr_imm} = 2'b11;
        CSRRSI:  {csr_set, csr_imm}  = 2'b11;
        CSRRCI:  {csr_clr, csr_imm}  = 2'b11;
        default: csr_imm = 1'b0;
      endcase
    end
  end

  always_comb begin
    ctrl_o.opcode      = opcode;
    ctrl_o.rs1         = r_fmt.rs1;
    ctrl_o.rs2         = r_fmt.rs2;
    ctrl_o.rd          = r_fmt.rd;
    ctrl_o.alu_op      = alu_op;
    ctrl_o.alu_a_sel   = (opcode == AUIPC);
    ctrl_o.alu_b_sel   = !(opcode == REGREG || opcode == BRANCH);
    ctrl_o.imm         = imm_sel;
    ctrl_o.w_sel       = (opcode == JAL || opcode == JALR) ? WB_LINK :
                         (opcode == LUI) ? WB_UIMM : WB_ALU;
    ctrl_o.wen         = wen_raw && !illegal;
    ctrl_o.dren        = (opcode == LOAD);
    ctrl_o.dwen        = (opcode == STORE);
    ctrl_o.load_type   = load_t'(i_fmt.funct3);
    ctrl_o.branch      = (opcode == BRANCH);
    ctrl_o.branch_type = branch_t'(sb_fmt.funct3);
    ctrl_o.jump        = (opcode == JAL || opcode == JALR);
    ctrl_o.csr_swap    = csr_swap;
    ctrl_o.csr_set     = csr_set;
    ctrl_o.csr_clr     = csr_clr;
    ctrl_o.csr_imm     = csr_imm;
    ctrl_o.csr_addr    = i_fmt.imm11_00;
    ctrl_o.zimm        = i_fmt.rs1;
    ctrl_o.ecall       = is_priv && (priv == ECALL);
    ctrl_o.ebreak      = is_priv && (priv == EBREAK);
    ctrl_o.mret        = is_priv && (priv == MRET);
    ctrl_o.illegal     = illegal;
    ctrl_o.halt        = INFINITE_LOOP_HALTS && (instr_i == HALT_INSN);
  end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none

module reg_file import rv32_core_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst_n_i,
  input  logic [REG_ADDR_W-1:0] rs1_i,
  input  logic [REG_ADDR_W-1:0] rs2_i,
  input  logic [REG_ADDR_W-1:0] rd_i,
  input  logic                  wen_i,
  input  logic [XLEN-1:0]       wdata_i,
  output logic [XLEN-1:0]       rdata1_o,
  output logic [XLEN-1:0]       rdata2_o
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // Same-cycle write is forwarded to the reader
  always_comb begin
    if (rs1_i == '0)                 rdata1_o = '0;
    else if (wen_i && rd_i == rs1_i) rdata1_o = wdata_i;
    else                             rdata1_o = regs[rs1_i];

    if (rs2_i == '0)                 rdata2_o = '0;
    else if (wen_i && rd_i == rs2_i) rdata2_o = wdata_i;
    else                             rdata2_o = regs[rs2_i];
  end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`default_nettype none

module alu import rv32_core_pkg::*; (
  input  alu_op_t         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o
);

  logic [SHAMT_W-1:0] shamt;

  assign shamt = b_i[SHAMT_W-1:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      // Compares give 0 or 1
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      default:  result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/stage_reg.sv ====
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     CLK,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload holds its value across idle cycles
  always_ff @(posedge CLK) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/rv32_decode_exec.sv ====
`default_nettype none

module rv32_decode_exec import rv32_core_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n_i,
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  output logic            commit_valid_o,
  output commit_t         commit_o
);

  ctrl_t           dec_ctrl;
  logic [XLEN-1:0] rs1_val, rs2_val;
  ex_req_t         ex_req_d, ex_req;
  logic            ex_valid;
  logic [XLEN-1:0] alu_a, alu_b, alu_result;
  logic [XLEN-1:0] pc_plus4;
  logic            wr_en;
  commit_t         commit_d;

  control_unit u_control_unit (
    .instr_i (instr_i),
    .ctrl_o  (dec_ctrl)
  );

  reg_file u_reg_file (
    .CLK      (CLK),
    .rst_n_i  (rst_n_i),
    .rs1_i    (dec_ctrl.rs1),
    .rs2_i    (dec_ctrl.rs2),
    .rd_i     (ex_req.ctrl.rd),
    .wen_i    (ex_valid && wr_en),
    .wdata_i  (commit_d.wdata),
    .rdata1_o (rs1_val),
    .rdata2_o (rs2_val)
  );

  always_comb begin
    ex_req_d.ctrl    = dec_ctrl;
    ex_req_d.rs1_val = rs1_val;
    ex_req_d.rs2_val = rs2_val;
    ex_req_d.pc      = pc_i;
  end

  stage_reg #(.payload_t(ex_req_t)) ex_stage (
    .CLK     (CLK),
    .rst_n_i (rst_n_i),
    .valid_i (instr_valid_i),
    .data_i  (ex_req_d),
    .valid_o (ex_valid),
    .data_o  (ex_req)
  );

  // Execute operands
  assign alu_a    = ex_req.ctrl.alu_a_sel ? ex_req.pc : ex_req.rs1_val;
  assign alu_b    = ex_req.ctrl.alu_b_sel ? ex_req.ctrl.imm : ex_req.rs2_val;
  assign pc_plus4 = ex_req.pc + 32'd4;

  alu u_alu (
    .op_i     (ex_req.ctrl.alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  // Writes to x0 are dropped
  assign wr_en = ex_req.ctrl.wen && (ex_req.ctrl.rd != '0);

  always_comb begin
    commit_d.wen = wr_en;
    commit_d.rd  = ex_req.ctrl.rd;
    case (ex_req.ctrl.w_sel)
      WB_LINK: commit_d.wdata = pc_plus4;
      WB_UIMM: commit_d.wdata = ex_req.ctrl.imm;
      default: commit_d.wdata = alu_result;
    endcase
    commit_d.mem_req.dren      = ex_req.ctrl.dren;
    commit_d.mem_req.dwen      = ex_req.ctrl.dwen;
    commit_d.mem_req.load_type = ex_req.ctrl.load_type;
    commit_d.mem_req.addr      = alu_result;
    commit_d.mem_req.wdata     = ex_req.rs2_val;
    commit_d.branch      = ex_req.ctrl.branch;
    commit_d.branch_type = ex_req.ctrl.branch_type;
    commit_d.jump        = ex_req.ctrl.jump;
    commit_d.csr_swap    = ex_req.ctrl.csr_swap;
    commit_d.csr_set     = ex_req.ctrl.csr_set;
    commit_d.csr_clr     = ex_req.ctrl.csr_clr;
    commit_d.csr_imm     = ex_req.ctrl.csr_imm;
    commit_d.csr_addr    = ex_req.ctrl.csr_addr;
    // Immediate CSR forms take zimm zero-extended
    commit_d.csr_wdata   = ex_req.ctrl.csr_imm ?
                           {{(XLEN-REG_ADDR_W){1'b0}}, ex_req.ctrl.zimm} : ex_req.rs1_val;
    commit_d.ecall       = ex_req.ctrl.ecall;
    commit_d.ebreak      = ex_req.ctrl.ebreak;
    commit_d.mret        = ex_req.ctrl.mret;
    commit_d.illegal     = ex_req.ctrl.illegal;
    commit_d.halt        = ex_req.ctrl.halt;
  end

  stage_reg #(.payload_t(commit_t)) commit_stage (
    .CLK     (CLK),
    .rst_n_i (rst_n_i),
    .valid_i (ex_valid),
    .data_i  (commit_d),
    .valid_o (commit_valid_o),
    .data_o  (commit_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Architectural register state, updated in program order
logic [XLEN-1:0] model_regs [0:NUM_REGS-1];

function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [XLEN-1:0] x,
                                            input logic [XLEN-1:0] y);
  logic [4:0] sh;
  sh = y[4:0];
  case (f3)
    3'd0:    return alt ? x - y : x + y;
    3'd1:    return x << sh;
    // Signed compare from the sign bits first
    3'd2:    return {31'd0, (x[31] != y[31]) ? x[31] : (x < y)};
    3'd3:    return {31'd0, x < y};
    3'd4:    return x ^ y;
    3'd5:    return alt ? ((x >> sh) | ({XLEN{x[31]}} & ~({XLEN{1'b1}} >> sh))) : x >> sh;
    3'd6:    return x | y;
    default: return x & y;
  endcase
endfunction

// Expected commit record of one instruction
function automatic commit_t model_exec(input logic [XLEN-1:0] insn,
                                       input logic [XLEN-1:0] pc);
  commit_t         c;
  logic [2:0]      f3;
  logic [4:0]      rd;
  logic [XLEN-1:0] a, b, imm_i, imm_s, imm_u;
  logic            legal;
  f3    = insn[14:12];
  rd    = insn[11:7];
  a     = model_regs[insn[19:15]];
  b     = model_regs[insn[24:20]];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  imm_u = {insn[31:12], 12'd0};
  c     = '0;
  legal = 1'b1;
  case (insn[6:0])
    LUI:     c.wdata = imm_u;
    AUIPC:   c.wdata = pc + imm_u;
    JAL, JALR: begin
      c.wdata = pc + 32'd4;
      c.jump  = 1'b1;
    end
    IMMED:   c.wdata = alu_ref(f3, insn[30] && f3 == 3'd5, a, imm_i);
    REGREG: begin
      c.wdata = alu_ref(f3, insn[30], a, b);
      legal   = !insn[25];
    end
    LOAD: begin
      c.mem_req.dren      = 1'b1;
      c.mem_req.load_type = load_t'(f3);
      c.mem_req.addr      = a + imm_i;
    end
    STORE: begin
      c.mem_req.dwen  = 1'b1;
      c.mem_req.addr  = a + imm_s;
      c.mem_req.wdata = b;
    end
    BRANCH: begin
      c.branch      = 1'b1;
      c.branch_type = branch_t'(f3);
    end
    SYSTEM: begin
      c.ecall     = (f3 == 3'd0) && (insn[31:20] == 12'h000);
      c.ebreak    = (f3 == 3'd0) && (insn[31:20] == 12'h001);
      c.mret      = (f3 == 3'd0) && (insn[31:20] == 12'h302);
      c.csr_swap  = (f3[1:0] == 2'b01);
      c.csr_set   = (f3[1:0] == 2'b10);
      c.csr_clr   = (f3[1:0] == 2'b11);
      c.csr_imm   = f3[2] && (f3[1:0] != 2'b00);
      c.csr_addr  = insn[31:20];
      c.csr_wdata = f3[2] ? {27'd0, insn[19:15]} : a;
    end
    MISCMEM: legal = 1'b1;
    default: legal = 1'b0;
  endcase
  c.illegal = !legal;
  c.wen     = legal && rd != 5'd0 &&
              (insn[6:0] inside {LUI, AUIPC, JAL, JALR, IMMED, REGREG});
  c.rd      = rd;
  c.halt    = (insn == 32'h0000_006f);
  if (c.wen) begin
    model_regs[rd] = c.wdata;
  end
  return c;
endfunction

`endif

// ==== test/tb_rv32_decode_exec.sv ====
`default_nettype none

module tb_rv32_decode_exec import rv32_core_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RANDOM  = 3000;
  localparam int DRAIN_LIMIT = 50;

  logic            CLK;
  logic            rst_n_i;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_i;
  logic [XLEN-1:0] pc_i;
  logic            commit_valid_o;
  commit_t         commit_o;

  integer          seed;
  commit_t         exp_q[$];
  commit_t         exp_rec;
  logic [1:0]      valid_pipe;
  logic [XLEN-1:0] next_pc;
  logic [31:0]     rnd;
  int              n_checked;
  int              drain_cycles;

  `include "tb_ref_model.svh"

  rv32_decode_exec dut_i (
    .CLK            (CLK),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
    if (got !== want) begin
      $display("ERR %s: got %h expected %h", name, got, want);
      abort_run();
    end
  endtask

  task automatic check_valid(input logic got, input logic want);
    if (got !== want) begin
      $display("ERR commit_valid_o: got %h expected %h", got, want);
      abort_run();
    end
  endtask

  task automatic check_commit(input commit_t got, input commit_t want);
    compare_word("commit_o.wen", 32'(got.wen), 32'(want.wen));
    compare_word("commit_o.illegal", 32'(got.illegal), 32'(want.illegal));
    compare_word("commit_o.halt", 32'(got.halt), 32'(want.halt));
    compare_word("commit_o.jump", 32'(got.jump), 32'(want.jump));
    compare_word("commit_o.branch", 32'(got.branch), 32'(want.branch));
    compare_word("commit_o.mem_req.dren", 32'(got.mem_req.dren), 32'(want.mem_req.dren));
    compare_word("commit_o.mem_req.dwen", 32'(got.mem_req.dwen), 32'(want.mem_req.dwen));
    compare_word("commit_o.csr_swap", 32'(got.csr_swap), 32'(want.csr_swap));
    compare_word("commit_o.csr_set", 32'(got.csr_set), 32'(want.csr_set));
    compare_word("commit_o.csr_clr", 32'(got.csr_clr), 32'(want.csr_clr));
    compare_word("commit_o.csr_imm", 32'(got.csr_imm), 32'(want.csr_imm));
    compare_word("commit_o.ecall", 32'(got.ecall), 32'(want.ecall));
    compare_word("commit_o.ebreak", 32'(got.ebreak), 32'(want.ebreak));
    compare_word("commit_o.mret", 32'(got.mret), 32'(want.mret));
    if (want.wen) begin
      compare_word("commit_o.rd", 32'(got.rd), 32'(want.rd));
      compare_word("commit_o.wdata", got.wdata, want.wdata);
    end
    if (want.mem_req.dren) begin
      compare_word("commit_o.mem_req.load_type", 32'(got.mem_req.load_type),
                   32'(want.mem_req.load_type));
    end
    if (want.mem_req.dren || want.mem_req.dwen) begin
      compare_word("commit_o.mem_req.addr", got.mem_req.addr, want.mem_req.addr);
    end
    if (want.mem_req.dwen) begin
      compare_word("commit_o.mem_req.wdata", got.mem_req.wdata, want.mem_req.wdata);
    end
    if (want.branch) begin
      compare_word("commit_o.branch_type", 32'(got.branch_type), 32'(want.branch_type));
    end
    if (want.csr_swap || want.csr_set || want.csr_clr) begin
      compare_word("commit_o.csr_addr", 32'(got.csr_addr), 32'(want.csr_addr));
      compare_word("commit_o.csr_wdata", got.csr_wdata, want.csr_wdata);
    end
  endtask

  // Mostly the low eight registers so results feed later operands
  function automatic logic [4:0] pick_reg(input logic [31:0] r);
    return (r[7:6] == 2'b00) ? r[4:0] : {2'b00, r[2:0]};
  endfunction

  function automatic logic [XLEN-1:0] random_insn();
    logic [31:0]     r;
    logic [XLEN-1:0] insn;
    r           = $random(seed);
    insn        = $random(seed);
    insn[11:7]  = pick_reg($random(seed));
    insn[19:15] = pick_reg($random(seed));
    insn[24:20] = pick_reg($random(seed));
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: begin
        insn[6:0] = IMMED;
        // Shift immediates carry a funct7
        if (insn[13:12] == 2'b01) begin
          insn[31:25] = {1'b0, r[8], 5'd0};
        end
      end
      4'd4, 4'd5, 4'd6: begin
        insn[6:0]   = REGREG;
        insn[31:25] = {1'b0, r[8], 5'd0};
      end
      4'd7: insn[6:0] = r[8] ? LUI : AUIPC;
      4'd8: begin
        insn[6:0] = r[8] ? JAL : JALR;
        if (!r[8]) begin
          insn[14:12] = 3'd0;
        end
      end
      4'd9: begin
        insn[6:0] = LOAD;
        if (insn[13:12] == 2'b11 || insn[14:13] == 2'b11) begin
          insn[14:12] = 3'd2;
        end
      end
      4'd10: begin
        insn[6:0] = STORE;
        insn[14]  = 1'b0;
        if (insn[13:12] == 2'b11) begin
          insn[13:12] = 2'b10;
        end
      end
      4'd11: begin
        insn[6:0] = BRANCH;
        if (insn[14:13] == 2'b01) begin
          insn[13] = 1'b0;
        end
      end
      4'd12: begin
        case (r[6:4])
          3'd0:    insn = 32'h0000_0073;
          3'd1:    insn = 32'h0010_0073;
          3'd2:    insn = 32'h3020_0073;
          default: begin
            insn[6:0]   = SYSTEM;
            insn[14:12] = (r[9:7] == 3'd0 || r[9:7] == 3'd4) ? 3'd2 : r[9:7];
          end
        endcase
      end
      4'd13: begin
        // Unknown major opcodes and M-extension words
        case (r[5:4])
          2'd0:    insn[6:0] = 7'b1010011;
          2'd1:    insn[6:0] = 7'b0101111;
          2'd2:    insn[6:0] = 7'b1111111;
          default: begin
            insn[6:0]   = REGREG;
            insn[31:25] = 7'b0000001;
          end
        endcase
      end
      4'd14:   insn = 32'h0000_006f;
      default: insn[6:0] = MISCMEM;
    endcase
    return insn;
  endfunction

  task automatic issue(input logic [XLEN-1:0] insn);
    @(posedge CLK);
    instr_valid_i <= 1'b1;
    instr_i       <= insn;
    pc_i          <= next_pc;
    exp_q.push_back(model_exec(insn, next_pc));
    next_pc = next_pc + 32'd4;
  endtask

  // Garbage on instr_i while the strobe is low
  task automatic idle();
    @(posedge CLK);
    instr_valid_i <= 1'b0;
    instr_i       <= $random(seed);
  endtask

  // Outputs sampled mid-cycle, three falling edges after the drive edge
  always @(negedge CLK) begin
    if (rst_n_i) begin
      check_valid(commit_valid_o, valid_pipe[1]);
      if (commit_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("A commit arrived with no instruction outstanding");
          abort_run();
        end
        exp_rec = exp_q.pop_front();
        check_commit(commit_o, exp_rec);
        n_checked++;
      end
    end
    valid_pipe = {valid_pipe[0], instr_valid_i && rst_n_i};
  end

  initial begin
    seed          = 32'he474_e941;
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    next_pc       = 32'h0000_1000;
    valid_pipe    = '0;
    n_checked     = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge CLK);
    rst_n_i <= 1'b1;

    // Stores expose every register, all zero after reset
    for (int i = 1; i < NUM_REGS; i++) begin
      issue({7'd0, 5'(i), 5'd0, 3'b010, 5'd0, STORE});
    end
    idle();

    // Dependent chain on consecutive edges
    issue({12'h123, 5'd0, 3'b000, 5'd5, IMMED});
    issue({7'h00, 5'd5, 5'd5, 3'b000, 5'd6, REGREG});
    issue({7'h20, 5'd5, 5'd6, 3'b000, 5'd7, REGREG});
    issue({20'habcde, 5'd8, LUI});
    issue({7'h20, 5'd5, 5'd8, 3'b101, 5'd9, REGREG});
    issue({12'h010, 5'd9, 3'b000, 5'd1, JALR});
    issue({20'h00800, 5'd2, JAL});
    issue(32'h0000_006f);
    idle();
    idle();

    for (int n = 0; n < NUM_RANDOM; n++) begin
      rnd = $random(seed);
      if (rnd[2:0] == 3'd0) begin
        idle();
      end
      issue(random_insn());
    end
    idle();

    drain_cycles = 0;
    while (exp_q.size() != 0 && drain_cycles < DRAIN_LIMIT) begin
      @(posedge CLK);
      drain_cycles++;
    end
    if (exp_q.size() == 0 && n_checked > 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Timed out with %0d commits still outstanding", exp_q.size());
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== rv32_decode_exec.f ====
+incdir+test
src/rv32_core_pkg.sv
src/control_unit.sv
src/reg_file.sv
src/alu.sv
src/stage_reg.sv
src/rv32_decode_exec.sv
test/tb_rv32_decode_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
  --timescale 1ns/100ps \
  -f rv32_decode_exec.f \
  --top-module tb_rv32_decode_exec \
  -o tb_rv32_decode_exec

# A failing run still leaves its log for the search below
./obj_dir/tb_rv32_decode_exec > sim.log 2>&1 || true
cat sim.log

if grep -qx "All tests passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
